// ==== sim.f ====
+incdir+testbench
source/firPkg.sv
source/firRegs.sv
source/firDecimator.sv
source/sampleBuffer.sv
source/hostPort.sv
source/firSubsystem.sv
testbench/firSubsystemTb.sv

// ==== source/firDecimator.sv ====
`timescale 1ns/10ps
`default_nettype none

module firDecimator (
   input wire clk,
   input wire arst,
   input wire sampleStb,
   input wire firPkg::sample_t sampleIn,
   input wire running,
   input wire firPkg::freqCode_t freqCode,
   input wire freqLoad,
   output firPkg::outSample_t outSample
);

   logic accepted;
   logic keep;
   logic outValid;
   logic signed [31:0] acc;
   logic signed [31:0] shifted;
   firPkg::sample_t dly0;
   firPkg::sample_t dly1;
   firPkg::sample_t dly2;
   firPkg::sample_t outValue;
   firPkg::freqCode_t decCnt;
   firPkg::freqCode_t decCntNext;

   // Samples that arrive while stopped are dropped here.
   assign accepted = sampleStb && running;

   // The accumulator is wide enough that the tap sum never overflows.
   always_comb begin
      acc = 32'(sampleIn) * firPkg::tap0
          + 32'(dly0) * firPkg::tap1
          + 32'(dly1) * firPkg::tap2
          + 32'(dly2) * firPkg::tap3;
      shifted = acc >>> firPkg::tapShift;
   end

   always_ff @(posedge clk or posedge arst) begin
      if (arst) begin
         dly0 <= '0;
         dly1 <= '0;
         dly2 <= '0;
      end else if (accepted) begin
         dly0 <= sampleIn;
         dly1 <= dly0;
         dly2 <= dly1;
      end
   end

   // A code of 0 or 1 lets every result through.
   assign decCntNext = decCnt + 7'd1;
   assign keep = decCntNext >= freqCode;

   always_ff @(posedge clk or posedge arst) begin
      if (arst) begin
         decCnt <= '0;
      end else if (freqLoad) begin
         decCnt <= '0;
      end else if (accepted) begin
         if (keep) begin
            decCnt <= '0;
         end else begin
            decCnt <= decCntNext;
         end
      end
   end

   always_ff @(posedge clk or posedge arst) begin
      if (arst) begin
         outValid <= 1'b0;
      end else begin
         outValid <= accepted && keep;
      end
   end

   always_ff @(posedge clk) begin
      if (accepted) begin
         outValue <= shifted[15:0];
      end
   end

   assign outSample.valid = outValid;
   assign outSample.value = outValue;

endmodule

`default_nettype wire

// ==== source/firPkg.sv ====
`default_nettype none

package firPkg;

   typedef logic signed [15:0] sample_t;
   typedef logic [13:0] hostAddr_t;
   typedef logic [23:0] hostData_t;
   typedef logic [15:0] regWord_t;
   typedef logic [10:0] bufPtr_t;
   typedef logic [6:0] freqCode_t;

   // Register map, selected by host address bits 2:0.
   localparam logic [2:0] regEscr = 3'd0;
   localparam logic [2:0] regWptr = 3'd1;
   localparam logic [2:0] regIcnt = 3'd2;
   localparam logic [2:0] regFreq = 3'd3;
   localparam logic [2:0] regOcnt = 3'd4;
   localparam logic [2:0] regFcnt = 3'd5;

   // Bit positions inside ESCR and FREQ.
   localparam int setClrBit = 15;
   localparam int ovflMaskBit = 10;
   localparam int wmiMaskBit = 9;
   localparam int startBit = 3;
   localparam int ovflBit = 2;
   localparam int wmiBit = 1;
   localparam int newFreqBit = 14;
   localparam int freqLoadBit = 7;

   localparam freqCode_t freqReset = 7'h41;
   localparam logic [7:0] wmReset = 8'hFF;

   // Filter taps sum to 8, so the shift restores unity gain.
   localparam int tap0 = 1;
   localparam int tap1 = 3;
   localparam int tap2 = 3;
   localparam int tap3 = 1;
   localparam int tapShift = 3;

   localparam int bufDepth = 1024;

   typedef struct packed {
      logic stb;
      logic [2:0] addr;
      hostData_t data;
   } regWrite_t;

   typedef struct packed {
      regWord_t escr;
      regWord_t wptr;
      regWord_t icnt;
      regWord_t freq;
      regWord_t ocnt;
      regWord_t fcnt;
   } regImage_t;

   typedef struct packed {
      logic valid;
      sample_t value;
   } outSample_t;

endpackage

`default_nettype wire

// ==== source/firRegs.sv ====
`timescale 1ns/10ps
`default_nettype none

module firRegs (
   input wire clk,
   input wire arst,
   input wire firPkg::regWrite_t regWr,
   input wire sampleStb,
   input wire firPkg::outSample_t outSample,
   output firPkg::regImage_t regs,
   output logic running,
   output firPkg::freqCode_t freqCode,
   output logic freqLoad,
   output firPkg::bufPtr_t wrPtr,
   output logic irq
);

   logic wrEscr;
   logic wrIcnt;
   logic wrFreq;
   logic wrOcnt;
   logic wrFcnt;
   logic escrSetClr;
   logic freqSetClr;
   logic ovflMask;
   logic wmiMask;
   logic ovfl;
   logic wmi;
   logic start;
   logic newFreq;
   logic validDly;
   logic [7:0] ocntWm;
   logic [7:0] ocntCnt;
   firPkg::bufPtr_t ptr;
   firPkg::bufPtr_t ptrNext;
   firPkg::regWord_t icnt;
   firPkg::regWord_t fcnt;
   firPkg::freqCode_t freqInt;

   assign wrEscr = regWr.stb && (regWr.addr == firPkg::regEscr);
   assign wrIcnt = regWr.stb && (regWr.addr == firPkg::regIcnt);
   assign wrFreq = regWr.stb && (regWr.addr == firPkg::regFreq);
   assign wrOcnt = regWr.stb && (regWr.addr == firPkg::regOcnt);
   assign wrFcnt = regWr.stb && (regWr.addr == firPkg::regFcnt);

   // Set/clear markers are visible in the read image only during the write.
   assign escrSetClr = wrEscr && regWr.data[firPkg::setClrBit];
   assign freqSetClr = wrFreq && regWr.data[firPkg::setClrBit];
   assign freqLoad = wrFreq && regWr.data[firPkg::freqLoadBit];

   always_ff @(posedge clk or posedge arst) begin
      if (arst) begin
         ovflMask <= 1'b0;
         wmiMask <= 1'b0;
         start <= 1'b0;
      end else if (wrEscr) begin
         if (regWr.data[firPkg::ovflMaskBit]) begin
            ovflMask <= regWr.data[firPkg::setClrBit];
         end
         if (regWr.data[firPkg::wmiMaskBit]) begin
            wmiMask <= regWr.data[firPkg::setClrBit];
         end
         if (regWr.data[firPkg::startBit]) begin
            start <= regWr.data[firPkg::setClrBit];
         end
      end
   end

   // Hardware events win over a software clear for both flags.
   always_ff @(posedge clk or posedge arst) begin
      if (arst) begin
         ovfl <= 1'b0;
      end else if (ptr[10]) begin
         ovfl <= 1'b1;
      end else if (wrEscr && regWr.data[firPkg::ovflBit]) begin
         ovfl <= regWr.data[firPkg::setClrBit];
      end
   end

   always_ff @(posedge clk or posedge arst) begin
      if (arst) begin
         validDly <= 1'b0;
         wmi <= 1'b0;
      end else begin
         validDly <= outSample.valid;
         if (validDly && (ocntCnt == ocntWm)) begin
            wmi <= 1'b1;
         end else if (wrEscr && regWr.data[firPkg::wmiBit]) begin
            wmi <= regWr.data[firPkg::setClrBit];
         end
      end
   end

   // The wrap bit is dropped on the edge after it appears.
   always_comb begin
      ptrNext = ptr + firPkg::bufPtr_t'(outSample.valid);
      if (ptr[10]) begin
         ptrNext[10] = 1'b0;
      end
   end

   always_ff @(posedge clk or posedge arst) begin
      if (arst) begin
         ptr <= '0;
         icnt <= '0;
         fcnt <= '0;
         ocntWm <= firPkg::wmReset;
         ocntCnt <= '0;
      end else begin
         ptr <= ptrNext;
         if (wrIcnt) begin
            icnt <= regWr.data[15:0];
         end else begin
            icnt <= icnt + firPkg::regWord_t'(sampleStb);
         end
         if (wrFcnt) begin
            fcnt <= regWr.data[15:0];
         end else if (start) begin
            fcnt <= fcnt + 16'd1;
         end
         if (wrOcnt) begin
            ocntWm <= regWr.data[15:8];
            ocntCnt <= regWr.data[7:0];
         end else begin
            ocntCnt <= ocntCnt + 8'(outSample.valid);
         end
      end
   end

   always_ff @(posedge clk or posedge arst) begin
      if (arst) begin
         freqInt <= firPkg::freqReset;
         newFreq <= 1'b0;
      end else begin
         if (freqLoad) begin
            freqInt <= regWr.data[6:0];
         end
         if (wrFreq && regWr.data[firPkg::newFreqBit]) begin
            newFreq <= regWr.data[firPkg::setClrBit];
         end
      end
   end

   always_comb begin
      regs.escr = '0;
      regs.escr[firPkg::setClrBit] = escrSetClr;
      regs.escr[firPkg::ovflMaskBit] = ovflMask;
      regs.escr[firPkg::wmiMaskBit] = wmiMask;
      regs.escr[firPkg::startBit] = start;
      regs.escr[firPkg::ovflBit] = ovfl;
      regs.escr[firPkg::wmiBit] = wmi;
      regs.wptr = {6'd0, ptr[9:0]};
      regs.icnt = icnt;
      regs.freq = '0;
      regs.freq[firPkg::setClrBit] = freqSetClr;
      regs.freq[firPkg::newFreqBit] = newFreq;
      regs.freq[firPkg::freqLoadBit] = freqLoad;
      regs.freq[6:0] = freqInt;
      regs.ocnt = {ocntWm, ocntCnt};
      regs.fcnt = fcnt;
   end

   assign running = start;
   assign freqCode = freqInt;
   assign wrPtr = ptr;
   assign irq = (ovfl && ovflMask) || (wmi && wmiMask);

endmodule

`default_nettype wire

// ==== source/firSubsystem.sv ====
`timescale 1ns/10ps
`default_nettype none

module firSubsystem (
   input wire clk,
   input wire arst,
   input wire hostWrStb,
   input wire firPkg::hostAddr_t hostAddr,
   input wire firPkg::hostData_t hostWrData,
   input wire hostRdStb,
   input wire firPkg::hostAddr_t hostRdAddr,
   input wire sampleStb,
   input wire firPkg::sample_t sampleIn,
   output logic hostRdValid,
   output firPkg::regWord_t hostRdData,
   output logic irq
);

   firPkg::regWrite_t regWr;
   firPkg::regImage_t regs;
   firPkg::outSample_t outSample;
   firPkg::freqCode_t freqCode;
   firPkg::bufPtr_t wrPtr;
   firPkg::regWord_t rdWord;
   logic running;
   logic freqLoad;
   logic [$clog2(firPkg::bufDepth)-1:0] bufRdAddr;

   hostPort uHostPort (
      .clk(clk),
      .arst(arst),
      .hostWrStb(hostWrStb),
      .hostAddr(hostAddr),
      .hostWrData(hostWrData),
      .hostRdStb(hostRdStb),
      .hostRdAddr(hostRdAddr),
      .regs(regs),
      .rdWord(rdWord),
      .regWr(regWr),
      .bufRdAddr(bufRdAddr),
      .hostRdValid(hostRdValid),
      .hostRdData(hostRdData)
   );

   firRegs uFirRegs (
      .clk(clk),
      .arst(arst),
      .regWr(regWr),
      .sampleStb(sampleStb),
      .outSample(outSample),
      .regs(regs),
      .running(running),
      .freqCode(freqCode),
      .freqLoad(freqLoad),
      .wrPtr(wrPtr),
      .irq(irq)
   );

   firDecimator uFirDecimator (
      .clk(clk),
      .arst(arst),
      .sampleStb(sampleStb),
      .sampleIn(sampleIn),
      .running(running),
      .freqCode(freqCode),
      .freqLoad(freqLoad),
      .outSample(outSample)
   );

   sampleBuffer uSampleBuffer (
      .clk(clk),
      .outSample(outSample),
      .wrPtr(wrPtr),
      .rdAddr(bufRdAddr),
      .rdWord(rdWord)
   );

endmodule

`default_nettype wire

// ==== source/hostPort.sv ====
`timescale 1ns/10ps
`default_nettype none

module hostPort (
   input wire clk,
   input wire arst,
   input wire hostWrStb,
   input wire firPkg::hostAddr_t hostAddr,
   input wire firPkg::hostData_t hostWrData,
   input wire hostRdStb,
   input wire firPkg::hostAddr_t hostRdAddr,
   input wire firPkg::regImage_t regs,
   input wire firPkg::regWord_t rdWord,
   output firPkg::regWrite_t regWr,
   output logic [$clog2(firPkg::bufDepth)-1:0] bufRdAddr,
   output logic hostRdValid,
   output firPkg::regWord_t hostRdData
);

   logic rdSelBuf;
   firPkg::regWord_t regRdMux;
   firPkg::regWord_t regRdWord;

   // Buffer space is read-only, so writes there are dropped.
   assign regWr.stb = hostWrStb && !hostAddr[13];
   assign regWr.addr = hostAddr[2:0];
   assign regWr.data = hostWrData;

   assign bufRdAddr = hostRdAddr[9:0];

   always_comb begin
      case (hostRdAddr[2:0])
         firPkg::regEscr: regRdMux = regs.escr;
         firPkg::regWptr: regRdMux = regs.wptr;
         firPkg::regIcnt: regRdMux = regs.icnt;
         firPkg::regFreq: regRdMux = regs.freq;
         firPkg::regOcnt: regRdMux = regs.ocnt;
         firPkg::regFcnt: regRdMux = regs.fcnt;
         default: regRdMux = '0;
      endcase
   end

   always_ff @(posedge clk or posedge arst) begin
      if (arst) begin
         hostRdValid <= 1'b0;
         rdSelBuf <= 1'b0;
      end else begin
         hostRdValid <= hostRdStb;
         if (hostRdStb) begin
            rdSelBuf <= hostRdAddr[13];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (hostRdStb) begin
         regRdWord <= regRdMux;
      end
   end

   // The memory output already carries one cycle of latency.
   assign hostRdData = rdSelBuf ? rdWord : regRdWord;

endmodule

`default_nettype wire

// ==== source/sampleBuffer.sv ====
`timescale 1ns/10ps
`default_nettype none

module sampleBuffer (
   input wire clk,
   input wire firPkg::outSample_t outSample,
   input wire firPkg::bufPtr_t wrPtr,
   input wire [$clog2(firPkg::bufDepth)-1:0] rdAddr,
   output firPkg::regWord_t rdWord
);

   firPkg::regWord_t mem [firPkg::bufDepth];

   // Only the low ten pointer bits address the memory.
   always_ff @(posedge clk) begin
      if (outSample.valid) begin
         mem[wrPtr[9:0]] <= outSample.value;
      end
   end

   always_ff @(posedge clk) begin
      rdWord <= mem[rdAddr];
   end

endmodule

`default_nettype wire

// ==== testbench/firRefModel.svh ====
function automatic logic [31:0] xorshift32(input logic [31:0] state);
   logic [31:0] x;
   x = state;
   x = x ^ (x << 13);
   x = x ^ (x >> 17);
   x = x ^ (x << 5);
   return x;
endfunction

// Weighted sum of the newest sample and three older ones, scaled back by the shift.
function automatic firPkg::sample_t firResult(
   input firPkg::sample_t x,
   input firPkg::sample_t d0,
   input firPkg::sample_t d1,
   input firPkg::sample_t d2
);
   int acc;
   int shifted;
   acc = int'(x) * firPkg::tap0 + int'(d0) * firPkg::tap1
       + int'(d1) * firPkg::tap2 + int'(d2) * firPkg::tap3;
   shifted = acc >>> firPkg::tapShift;
   return shifted[15:0];
endfunction

// The count includes the current result.
function automatic logic keptByDecimator(input int count, input int code);
   return (code <= 1) || (count >= code);
endfunction

function automatic firPkg::regWord_t escrWord(
   input logic ovflMask,
   input logic wmiMask,
   input logic start,
   input logic ovfl,
   input logic wmi
);
   firPkg::regWord_t w;
   w = '0;
   w[firPkg::ovflMaskBit] = ovflMask;
   w[firPkg::wmiMaskBit] = wmiMask;
   w[firPkg::startBit] = start;
   w[firPkg::ovflBit] = ovfl;
   w[firPkg::wmiBit] = wmi;
   return w;
endfunction

function automatic firPkg::regWord_t freqWord(input logic newFreq, input int code);
   firPkg::regWord_t w;
   w = '0;
   w[firPkg::newFreqBit] = newFreq;
   w[6:0] = code[6:0];
   return w;
endfunction

// ==== testbench/firSubsystemTb.sv ====
`timescale 1ns/10ps
`default_nettype none

module firSubsystemTb;

   // Rough cycle budget of tests 1 to 6, in order.
   localparam int plannedCycles = 40 + 200 + 60 + 120 + 2150 + 60;
   localparam int cycleLimit = 2 * plannedCycles + 200;

   logic clk;
   logic arst;
   logic hostWrStb;
   logic hostRdStb;
   logic sampleStb;
   logic hostRdValid;
   logic irq;
   firPkg::hostAddr_t hostAddr;
   firPkg::hostAddr_t hostRdAddr;
   firPkg::hostData_t hostWrData;
   firPkg::sample_t sampleIn;
   firPkg::regWord_t hostRdData;

   firPkg::regWord_t expQ[$];
   string nameQ[$];
   firPkg::regWord_t expBuf [firPkg::bufDepth];
   firPkg::sample_t d0 = 0;
   firPkg::sample_t d1 = 0;
   firPkg::sample_t d2 = 0;
   firPkg::regWord_t icntModel = 0;
   logic [7:0] ocntCnt = 8'h00;
   logic [7:0] wmModel = 8'hFF;
   logic [31:0] rng = 32'h8fec_2a3b;
   logic mOvflMask = 0;
   logic mWmiMask = 0;
   logic mStart = 0;
   logic mOvfl = 0;
   logic mWmi = 0;
   logic mNewFreq = 0;
   logic rdStbSeen = 1'b0;
   int decCount = 0;
   int code = 7'h41;
   int ptrModel = 0;
   int cycleCount = 0;

   `include "firRefModel.svh"

   firSubsystem dut (
      .clk(clk),
      .arst(arst),
      .hostWrStb(hostWrStb),
      .hostAddr(hostAddr),
      .hostWrData(hostWrData),
      .hostRdStb(hostRdStb),
      .hostRdAddr(hostRdAddr),
      .sampleStb(sampleStb),
      .sampleIn(sampleIn),
      .hostRdValid(hostRdValid),
      .hostRdData(hostRdData),
      .irq(irq)
   );

   initial clk = 1'b0;
   always #20 clk = ~clk;

   task automatic stopWithFailure(input string why);
      $display("%s", why);
      $display("Errors found");
      $fatal(1);
   endtask

   task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         stopWithFailure($sformatf("FAIL at %0t: %s is 0x%0h, expected 0x%0h",
                                   $time, name, got, exp));
      end
   endtask

   task automatic tick();
      @(posedge clk);
      #2;
   endtask

   task automatic settle();
      repeat (3) tick();
   endtask

   task automatic writeReg(input logic [2:0] addr, input firPkg::hostData_t data);
      hostWrStb = 1'b1;
      hostAddr = {11'd0, addr};
      hostWrData = data;
      tick();
      hostWrStb = 1'b0;
   endtask

   // Every selected ESCR bit takes the value of the set/clear bit.
   task automatic writeEscr(input logic set, input logic [14:0] bits);
      writeReg(firPkg::regEscr, {8'd0, set, bits});
      if (bits[firPkg::ovflMaskBit]) mOvflMask = set;
      if (bits[firPkg::wmiMaskBit]) mWmiMask = set;
      if (bits[firPkg::startBit]) mStart = set;
      if (bits[firPkg::ovflBit]) mOvfl = set;
      if (bits[firPkg::wmiBit]) mWmi = set;
   endtask

   task automatic sendSample(input firPkg::sample_t v);
      firPkg::sample_t y;
      sampleStb = 1'b1;
      sampleIn = v;
      icntModel = icntModel + 16'd1;
      if (mStart) begin
         y = firResult(v, d0, d1, d2);
         d2 = d1;
         d1 = d0;
         d0 = v;
         decCount = decCount + 1;
         if (keptByDecimator(decCount, code)) begin
            decCount = 0;
            expBuf[ptrModel] = y;
            ptrModel = (ptrModel + 1) % firPkg::bufDepth;
            ocntCnt = ocntCnt + 8'd1;
            if (ptrModel == 0) mOvfl = 1'b1;
         end
      end
      tick();
      sampleStb = 1'b0;
   endtask

   task automatic sendRandom();
      rng = xorshift32(rng);
      sendSample(rng[15:0]);
   endtask

   task automatic issueRead(input firPkg::hostAddr_t addr, input firPkg::regWord_t exp,
                            input string name);
      hostRdStb = 1'b1;
      hostRdAddr = addr;
      expQ.push_back(exp);
      nameQ.push_back(name);
      tick();
      hostRdStb = 1'b0;
   endtask

   task automatic drainReads();
      while (expQ.size() != 0) begin
         tick();
      end
   endtask

   task automatic readReg(input logic [2:0] addr, input firPkg::regWord_t exp, input string name);
      issueRead({11'd0, addr}, exp, name);
      drainReads();
   endtask

   task automatic readBuffer(input int count);
      for (int i = 0; i < count; i++) begin
         issueRead(14'h2000 + 14'(i), expBuf[i], $sformatf("buffer[%0d]", i));
      end
      drainReads();
   endtask

   function automatic firPkg::regWord_t escrModel();
      return escrWord(mOvflMask, mWmiMask, mStart, mOvfl, mWmi);
   endfunction

   // The read strobe as the DUT saw it at the last rising edge.
   always @(posedge clk) begin
      rdStbSeen <= hostRdStb;
   end

   // Read data is stable at the falling edge after the valid pulse starts.
   always @(negedge clk) begin : compareReads
      string name;
      firPkg::regWord_t exp;
      checkValue("hostRdValid", hostRdValid, rdStbSeen);
      if (hostRdValid === 1'b1) begin
         if (expQ.size() == 0) begin
            stopWithFailure("Read data came back although no read was pending.");
         end else begin
            exp = expQ.pop_front();
            name = nameQ.pop_front();
            checkValue(name, hostRdData, exp);
         end
      end
   end

   always @(posedge clk) begin
      cycleCount = cycleCount + 1;
      if (cycleCount >= cycleLimit) begin
         stopWithFailure($sformatf("Timeout: the run did not end within %0d cycles.", cycleLimit));
      end
   end

   initial begin
      hostWrStb = 1'b0;
      hostAddr = '0;
      hostWrData = '0;
      hostRdStb = 1'b0;
      hostRdAddr = '0;
      sampleStb = 1'b0;
      sampleIn = '0;
      arst = 1'b1;
      repeat (8) @(posedge clk);
      #2;
      arst = 1'b0;

      readReg(firPkg::regEscr, 16'h0000, "ESCR");
      readReg(firPkg::regWptr, 16'h0000, "WPTR");
      readReg(firPkg::regIcnt, 16'h0000, "ICNT");
      readReg(firPkg::regFreq, 16'h0041, "FREQ");
      readReg(firPkg::regOcnt, 16'hFF00, "OCNT");
      readReg(firPkg::regFcnt, 16'h0000, "FCNT");
      readReg(3'd6, 16'h0000, "reg6");
      checkValue("irq", irq, 1'b0);

      // Code 3 with NEWFREQ set, then sixty samples with random gaps.
      writeReg(firPkg::regFreq, 24'h00C083);
      code = 3;
      decCount = 0;
      mNewFreq = 1'b1;
      writeEscr(1'b1, 15'(1 << firPkg::startBit));
      for (int i = 0; i < 60; i++) begin
         sendRandom();
         if (rng[20]) tick();
      end
      settle();
      readReg(firPkg::regWptr, 16'(ptrModel), "WPTR");
      readReg(firPkg::regOcnt, {wmModel, ocntCnt}, "OCNT");
      readReg(firPkg::regFreq, freqWord(mNewFreq, code), "FREQ");
      readReg(firPkg::regEscr, escrModel(), "ESCR");
      readBuffer(ptrModel);

      // Stopped samples are counted but not filtered.
      writeEscr(1'b0, 15'(1 << firPkg::startBit));
      repeat (5) sendRandom();
      settle();
      readReg(firPkg::regIcnt, icntModel, "ICNT");
      readReg(firPkg::regWptr, 16'(ptrModel), "WPTR");
      hostWrStb = 1'b1;
      hostAddr = {11'd0, firPkg::regIcnt};
      hostWrData = 24'h001200;
      sampleStb = 1'b1;
      tick();
      hostWrStb = 1'b0;
      sampleStb = 1'b0;
      icntModel = 16'h1200;
      repeat (3) sendRandom();
      settle();
      readReg(firPkg::regIcnt, icntModel, "ICNT");

      // Watermark two outputs ahead with the WMI mask on.
      writeEscr(1'b1, 15'(1 << firPkg::startBit));
      wmModel = ocntCnt + 8'd2;
      writeReg(firPkg::regOcnt, {8'd0, wmModel, ocntCnt});
      writeEscr(1'b1, 15'(1 << firPkg::wmiMaskBit));
      while (ocntCnt != wmModel) sendRandom();
      settle();
      mWmi = 1'b1;
      checkValue("irq", irq, 1'b1);
      readReg(firPkg::regEscr, escrModel(), "ESCR");
      writeEscr(1'b0, 15'(1 << firPkg::wmiBit));
      checkValue("irq", irq, 1'b0);
      writeEscr(1'b0, 15'(1 << firPkg::wmiMaskBit));
      wmModel = ocntCnt + 8'd1;
      writeReg(firPkg::regOcnt, {8'd0, wmModel, ocntCnt});
      while (ocntCnt != wmModel) sendRandom();
      settle();
      mWmi = 1'b1;
      checkValue("irq", irq, 1'b0);
      readReg(firPkg::regEscr, escrModel(), "ESCR");

      // Code 0 keeps every result, so 1024 samples wrap the pointer once.
      writeReg(firPkg::regFreq, 24'h000080);
      code = 0;
      decCount = 0;
      writeEscr(1'b1, 15'(1 << firPkg::ovflMaskBit));
      repeat (firPkg::bufDepth) sendRandom();
      settle();
      checkValue("irq", irq, 1'b1);
      readReg(firPkg::regWptr, 16'(ptrModel), "WPTR");
      readReg(firPkg::regOcnt, {wmModel, ocntCnt}, "OCNT");
      readReg(firPkg::regFreq, freqWord(mNewFreq, code), "FREQ");
      readReg(firPkg::regEscr, escrModel(), "ESCR");
      writeEscr(1'b0, 15'(1 << firPkg::ovflMaskBit));
      checkValue("irq", irq, 1'b0);
      readBuffer(firPkg::bufDepth);

      // START stays set for 25 idle cycles plus the cycle of the clearing write.
      writeEscr(1'b0, 15'(1 << firPkg::startBit));
      writeReg(firPkg::regFcnt, 24'h000100);
      writeEscr(1'b1, 15'(1 << firPkg::startBit));
      repeat (25) tick();
      writeEscr(1'b0, 15'(1 << firPkg::startBit));
      settle();
      readReg(firPkg::regFcnt, 16'h0100 + 16'd26, "FCNT");

      if (expQ.size() != 0) begin
         stopWithFailure("Some expected read data never came back.");
      end else begin
         $display("No errors");
         $finish;
      end
   end

endmodule

`default_nettype wire
